//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Checks failed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, scan $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bus_pkg.sv
// Wishbone and CSR bus definitions
// Shared widths of the external bus, the CSR bus and the bridge FSM

package bus_pkg;

	//----------------------------------------------------------------------
	// Wishbone side
	//----------------------------------------------------------------------

	// Byte address from the bus master
	typedef logic [31:0] wb_addr_t;

	// Data word, same on Wishbone and CSR
	typedef logic [31:0] wb_data_t;

	//----------------------------------------------------------------------
	// CSR side
	//----------------------------------------------------------------------

	// Word address, Wishbone bits 15..2
	typedef logic [13:0] csr_addr_t;

	// Upper CSR address bits pick the slave
	typedef logic [3:0] csr_bank_t;

	// Register index inside one bank
	localparam int CSR_REG_W = 5;

	// Bridge FSM, one CSR access per bus cycle
	typedef enum logic [1:0] {
		BR_IDLE,
		BR_ACCESS,
		BR_LATCH,
		BR_ACK
	} bridge_state_t;

endpackage

//--- reset_sequencer.sv
// Reset sequencer
// Stretches reset requests into the system reset, flash released early

module reset_sequencer (
	input  logic sys_clk,
	input  logic trigger_reset,
	input  logic hard_reset_i,
	output logic sys_rst_o,
	output logic flash_rst_n_o
);

	import system_pkg::*;

	logic       rst_req;
	rst_count_t hold_count;
	rst_count_t flash_count;

	// External trigger or software request
	always_ff @(posedge sys_clk) begin
		rst_req <= trigger_reset | hard_reset_i;
	end

	//----------------------------------------------------------------------
	// System reset hold
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			hold_count <= RST_HOLD_CYCLES;
		end else if (hold_count != '0) begin
			hold_count <= hold_count - 1'b1;
		end
		// Held until the count drains
		sys_rst_o <= (hold_count != '0);
	end

	//----------------------------------------------------------------------
	// Flash reset, shorter than the hold
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_req) begin
			flash_count <= '0;
		end else if (flash_count != FLASH_RST_CYCLES) begin
			flash_count <= flash_count + 1'b1;
		end
	end

	// Flash may fetch before the system leaves reset
	always_ff @(posedge sys_clk) begin
		flash_rst_n_o <= (flash_count == FLASH_RST_CYCLES) && !rst_req;
	end

endmodule

//--- soc_top.sv
// SoC top level
// Reset sequencer, Wishbone to CSR bridge and system controller

module soc_top (
	input  logic                  sys_clk,
	input  logic                  trigger_reset,

	// Wishbone slave port
	input  bus_pkg::wb_addr_t     wb_adr_i,
	input  bus_pkg::wb_data_t     wb_dat_i,
	output bus_pkg::wb_data_t     wb_dat_o,
	input  logic                  wb_we_i,
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	output logic                  wb_ack_o,

	// GPIO and interrupts
	input  system_pkg::gpio_in_t  btn_i,
	output system_pkg::gpio_out_t led_o,
	output system_pkg::irq_vec_t  irq_o,

	output logic                  sys_rst_o,
	output logic                  flash_rst_n_o
);

	import bus_pkg::*;

	logic      sys_rst;
	logic      hard_reset;

	// CSR bus
	csr_addr_t csr_a;
	logic      csr_we;
	wb_data_t  csr_dw;
	// Only one CSR slave left, no OR of read data
	wb_data_t  csr_dr;

	//----------------------------------------------------------------------
	// Reset generation
	//----------------------------------------------------------------------
	reset_sequencer reset_sequencer_i (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.hard_reset_i  (hard_reset),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n_o)
	);

	assign sys_rst_o = sys_rst;

	//----------------------------------------------------------------------
	// Bus bridge and CSR slave
	//----------------------------------------------------------------------
	wb_csr_bridge wb_csr_bridge_i (
		.sys_clk   (sys_clk),
		.sys_rst_i (sys_rst),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_dat_o  (wb_dat_o),
		.wb_we_i   (wb_we_i),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_ack_o  (wb_ack_o),
		.csr_a_o   (csr_a),
		.csr_we_o  (csr_we),
		.csr_dw_o  (csr_dw),
		.csr_dr_i  (csr_dr)
	);

	sysctl sysctl_i (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst),
		.csr_a_i      (csr_a),
		.csr_we_i     (csr_we),
		.csr_dw_i     (csr_dw),
		.csr_dr_o     (csr_dr),
		.btn_i        (btn_i),
		.led_o        (led_o),
		.irq_o        (irq_o),
		.hard_reset_o (hard_reset)
	);

endmodule

//--- sysctl.sv
// System controller on the CSR bus
// GPIO with change interrupt, two timers, identifiers and hard reset

module sysctl (
	input  logic                  sys_clk,
	input  logic                  sys_rst_i,

	// CSR slave
	input  bus_pkg::csr_addr_t    csr_a_i,
	input  logic                  csr_we_i,
	input  bus_pkg::wb_data_t     csr_dw_i,
	output bus_pkg::wb_data_t     csr_dr_o,

	// Board I/O
	input  system_pkg::gpio_in_t  btn_i,
	output system_pkg::gpio_out_t led_o,

	output system_pkg::irq_vec_t  irq_o,
	output logic                  hard_reset_o
);

	import bus_pkg::*;
	import system_pkg::*;

	csr_bank_t              bank;
	logic [CSR_REG_W-1:0]   reg_idx;
	logic                   bank_sel;
	logic                   wr;

	gpio_in_t  btn_meta;
	gpio_in_t  btn_sync;
	gpio_in_t  btn_prev;
	gpio_in_t  gpio_irq_en;
	gpio_out_t led;
	logic      gpio_irq;

	wb_data_t t0_ctrl, t0_compare, t0_counter;
	wb_data_t t1_ctrl, t1_compare, t1_counter;
	logic     t0_irq;
	logic     t1_irq;

	//----------------------------------------------------------------------
	// Address decode
	//----------------------------------------------------------------------
	assign bank     = csr_a_i[$bits(csr_addr_t)-1 -: $bits(csr_bank_t)];
	// Middle address bits are don't-care
	assign reg_idx  = csr_a_i[CSR_REG_W-1:0];
	assign bank_sel = (bank == SYSCTL_BANK);
	assign wr       = csr_we_i && bank_sel;

	//----------------------------------------------------------------------
	// GPIO
	//----------------------------------------------------------------------

	// Two-flop synchronizer, then previous value for edges
	always_ff @(posedge sys_clk) begin
		btn_meta <= btn_i;
		btn_sync <= btn_meta;
		btn_prev <= btn_sync;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			led         <= '0;
			gpio_irq_en <= '0;
			gpio_irq    <= 1'b0;
		end else begin
			if (wr && (reg_idx == REG_GPIO_OUT)) begin
				led <= csr_dw_i[$bits(gpio_out_t)-1:0];
			end
			if (wr && (reg_idx == REG_GPIO_IRQ_EN)) begin
				gpio_irq_en <= csr_dw_i[$bits(gpio_in_t)-1:0];
			end
			// Any enabled input changed
			gpio_irq <= |((btn_sync ^ btn_prev) & gpio_irq_en);
		end
	end

	assign led_o = led;

	//----------------------------------------------------------------------
	// Timers
	//----------------------------------------------------------------------
	sysctl_timer timer0 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_i),
		.wdata_i      (csr_dw_i),
		.ctrl_we_i    (wr && (reg_idx == REG_TIMER0_CTRL)),
		.compare_we_i (wr && (reg_idx == REG_TIMER0_COMPARE)),
		.counter_we_i (wr && (reg_idx == REG_TIMER0_COUNTER)),
		.ctrl_o       (t0_ctrl),
		.compare_o    (t0_compare),
		.counter_o    (t0_counter),
		.irq_o        (t0_irq)
	);

	sysctl_timer timer1 (
		.sys_clk      (sys_clk),
		.sys_rst_i    (sys_rst_i),
		.wdata_i      (csr_dw_i),
		.ctrl_we_i    (wr && (reg_idx == REG_TIMER1_CTRL)),
		.compare_we_i (wr && (reg_idx == REG_TIMER1_COMPARE)),
		.counter_we_i (wr && (reg_idx == REG_TIMER1_COUNTER)),
		.ctrl_o       (t1_ctrl),
		.compare_o    (t1_compare),
		.counter_o    (t1_counter),
		.irq_o        (t1_irq)
	);

	//----------------------------------------------------------------------
	// Read data and hard reset
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			csr_dr_o     <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			// Any write here restarts the whole system
			hard_reset_o <= wr && (reg_idx == REG_HARD_RESET);
			// Zero unless selected and readable
			csr_dr_o <= '0;
			if (bank_sel) begin
				case (reg_idx)
					REG_GPIO_IN:        csr_dr_o <= wb_data_t'(btn_sync);
					REG_GPIO_OUT:       csr_dr_o <= wb_data_t'(led);
					REG_GPIO_IRQ_EN:    csr_dr_o <= wb_data_t'(gpio_irq_en);
					REG_TIMER0_CTRL:    csr_dr_o <= t0_ctrl;
					REG_TIMER0_COMPARE: csr_dr_o <= t0_compare;
					REG_TIMER0_COUNTER: csr_dr_o <= t0_counter;
					REG_TIMER1_CTRL:    csr_dr_o <= t1_ctrl;
					REG_TIMER1_COMPARE: csr_dr_o <= t1_compare;
					REG_TIMER1_COUNTER: csr_dr_o <= t1_counter;
					REG_CAPABILITIES:   csr_dr_o <= CAPABILITIES;
					REG_SYSTEM_ID:      csr_dr_o <= SYSTEM_ID;
					default:            csr_dr_o <= '0;
				endcase
			end
		end
	end

	// Interrupt vector, upper bits unused
	always_comb begin
		irq_o = '0;
		irq_o[IRQ_GPIO]   = gpio_irq;
		irq_o[IRQ_TIMER0] = t0_irq;
		irq_o[IRQ_TIMER1] = t1_irq;
	end

endmodule

//--- sysctl_timer.sv
// Compare timer of the system controller
// Counts while enabled, pulses on match, then restarts or stops

module sysctl_timer (
	input  logic              sys_clk,
	input  logic              sys_rst_i,

	// Register writes
	input  bus_pkg::wb_data_t wdata_i,
	input  logic              ctrl_we_i,
	input  logic              compare_we_i,
	input  logic              counter_we_i,

	// Register readback
	output bus_pkg::wb_data_t ctrl_o,
	output bus_pkg::wb_data_t compare_o,
	output bus_pkg::wb_data_t counter_o,

	output logic              irq_o
);

	import bus_pkg::*;
	import system_pkg::*;

	logic     en;
	logic     ar;
	wb_data_t compare;
	wb_data_t counter;
	logic     match;

	// Match only counts while running
	assign match = en && (counter == compare);
	assign irq_o = match;

	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			en      <= 1'b0;
			ar      <= 1'b0;
			compare <= '0;
			counter <= '0;
		end else begin
			if (match) begin
				if (ar) begin
					counter <= '0;
				end else begin
					// One-shot, counter parks at compare
					en <= 1'b0;
				end
			end else if (en) begin
				counter <= counter + 1'b1;
			end

			// Bus writes win over counting
			if (ctrl_we_i) begin
				en <= wdata_i[TIMER_CTRL_EN_BIT];
				ar <= wdata_i[TIMER_CTRL_AR_BIT];
			end
			if (compare_we_i) begin
				compare <= wdata_i;
			end
			if (counter_we_i) begin
				counter <= wdata_i;
			end
		end
	end

	always_comb begin
		ctrl_o = '0;
		ctrl_o[TIMER_CTRL_EN_BIT] = en;
		ctrl_o[TIMER_CTRL_AR_BIT] = ar;
	end

	assign compare_o = compare;
	assign counter_o = counter;

endmodule

//--- system_pkg.sv
// System controller definitions
// Register map, interrupt positions, identifier words and reset counts

package system_pkg;

	// GPIO widths
	typedef logic [2:0] gpio_in_t;
	typedef logic [1:0] gpio_out_t;

	// CPU interrupt vector
	typedef logic [31:0] irq_vec_t;

	// Reset hold and flash counters
	typedef logic [7:0] rst_count_t;

	//----------------------------------------------------------------------
	// Register map
	//----------------------------------------------------------------------

	localparam bus_pkg::csr_bank_t SYSCTL_BANK = 4'd1;

	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_GPIO_IN        = 5'd0;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_GPIO_OUT       = 5'd1;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_GPIO_IRQ_EN    = 5'd2;

	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER0_CTRL    = 5'd4;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER0_COMPARE = 5'd5;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER0_COUNTER = 5'd6;

	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER1_CTRL    = 5'd8;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER1_COMPARE = 5'd9;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_TIMER1_COUNTER = 5'd10;

	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_CAPABILITIES   = 5'd16;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_SYSTEM_ID      = 5'd17;
	localparam logic [bus_pkg::CSR_REG_W-1:0] REG_HARD_RESET     = 5'd18;

	// Timer control word bits
	localparam int TIMER_CTRL_EN_BIT = 0;
	localparam int TIMER_CTRL_AR_BIT = 1;

	// Interrupt vector positions
	localparam int IRQ_GPIO   = 0;
	localparam int IRQ_TIMER0 = 1;
	localparam int IRQ_TIMER1 = 2;

	// "MONE"
	localparam bus_pkg::wb_data_t SYSTEM_ID = 32'h4D4F4E45;
	// Bit 0 GPIO, bit 1 timers
	localparam bus_pkg::wb_data_t CAPABILITIES = 32'h3;

	// Short hold so reset fits in simulation
	localparam rst_count_t RST_HOLD_CYCLES  = 8'd200;
	localparam rst_count_t FLASH_RST_CYCLES = 8'd128;

endpackage

//--- tb.f
bus_pkg.sv
system_pkg.sv
reset_sequencer.sv
wb_csr_bridge.sv
sysctl_timer.sv
sysctl.sv
soc_top.sv
tb_soc_top.sv

//--- tb_soc_top.sv
// Testbench for the SoC top level
// Wishbone master, register model, interrupt monitor and reset sequence checks

module tb_soc_top;

	localparam int CLK_HALF        = 4;
	localparam int RESET_CYCLES    = 10;
	localparam int HOLD_CYCLES     = 200;
	localparam int ACK_TIMEOUT     = 16;
	// Two resets of ~210 cycles, ~60 accesses of 6 cycles, timer runs under 250
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int unsigned SEED   = 32'h4693;

	// Byte addresses, bank in bits 15..12, word index in bits 6..2
	localparam logic [31:0] A_GPIO_IN  = 32'h0000_1000;
	localparam logic [31:0] A_GPIO_OUT = 32'h0000_1004;
	localparam logic [31:0] A_IRQ_EN   = 32'h0000_1008;
	localparam logic [31:0] A_T0_CTRL  = 32'h0000_1010;
	localparam logic [31:0] A_T0_CMP   = 32'h0000_1014;
	localparam logic [31:0] A_T0_CNT   = 32'h0000_1018;
	localparam logic [31:0] A_T1_CTRL  = 32'h0000_1020;
	localparam logic [31:0] A_T1_CMP   = 32'h0000_1024;
	localparam logic [31:0] A_T1_CNT   = 32'h0000_1028;
	localparam logic [31:0] A_CAPS     = 32'h0000_1040;
	localparam logic [31:0] A_SYS_ID   = 32'h0000_1044;
	localparam logic [31:0] A_HARD_RST = 32'h0000_1048;

	logic        sys_clk;
	logic        trigger_reset;
	logic [31:0] wb_adr;
	logic [31:0] wb_dat_wr;
	logic [31:0] wb_dat_rd;
	logic        wb_we;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_ack;
	logic [2:0]  btn;
	logic [1:0]  led;
	logic [31:0] irq;
	logic        sys_rst;
	logic        flash_rst_n;

	// Register model
	logic [1:0]  m_led;
	logic [2:0]  m_irq_en;
	logic [2:0]  m_btn;
	logic [31:0] m_t_ctrl [2];
	logic [31:0] m_t_cmp [2];
	logic [31:0] m_t_cnt [2];

	// Read results waiting for the compare process
	logic [31:0] addr_q [$];
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];
	logic [31:0] cmp_addr;
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;

	// Per-process error counts
	int main_errors;
	int cmp_errors;
	int mon_errors;
	int reads_checked;

	// Monitor state
	int   cycle;
	logic ack_prev;
	int   gpio_pulses;
	int   t0_pulses;
	int   t1_pulses;
	int   t1_last;
	int   t1_period;

	logic [31:0] rnd;
	logic [31:0] cmp;
	logic [31:0] rdata;
	int          base;
	int          waited;

	soc_top soc_top_i (
		.sys_clk       (sys_clk),
		.trigger_reset (trigger_reset),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_wr),
		.wb_dat_o      (wb_dat_rd),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_ack_o      (wb_ack),
		.btn_i         (btn),
		.led_o         (led),
		.irq_o         (irq),
		.sys_rst_o     (sys_rst),
		.flash_rst_n_o (flash_rst_n)
	);

	initial sys_clk = 1'b0;
	always #CLK_HALF sys_clk = ~sys_clk;

	//----------------------------------------------------------------------
	// Reference model of the register map
	//----------------------------------------------------------------------
	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		logic [31:0] val;
		val = 32'h0;
		// Only bank 1 decodes, everything else reads zero
		if (addr[15:12] == 4'd1) begin
			case (addr[6:2])
				5'd0:    val = {29'h0, m_btn};
				5'd1:    val = {30'h0, m_led};
				5'd2:    val = {29'h0, m_irq_en};
				5'd4:    val = m_t_ctrl[0];
				5'd5:    val = m_t_cmp[0];
				5'd6:    val = m_t_cnt[0];
				5'd8:    val = m_t_ctrl[1];
				5'd9:    val = m_t_cmp[1];
				5'd10:   val = m_t_cnt[1];
				5'd16:   val = 32'h0000_0003;
				5'd17:   val = 32'h4D4F_4E45;
				default: val = 32'h0;
			endcase
		end
		return val;
	endfunction

	// Model state after any reset
	task automatic clear_model();
		m_led    = 2'b0;
		m_irq_en = 3'b0;
		for (int i = 0; i < 2; i++) begin
			m_t_ctrl[i] = 32'h0;
			m_t_cmp[i]  = 32'h0;
			m_t_cnt[i]  = 32'h0;
		end
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("ERR %s got=%h exp=%h", name, got, exp);
		main_errors++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		main_errors++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	//----------------------------------------------------------------------
	// Wishbone master
	//----------------------------------------------------------------------

	// Holds the request until ack, or until reset if allowed
	task automatic wb_access(input logic [31:0] addr, input logic [31:0] data,
		input logic we, input logic allow_reset, output logic [31:0] rd);
		int   n;
		logic done;
		n    = 0;
		done = 1'b0;
		rd   = 32'h0;
		@(posedge sys_clk);
		wb_adr    <= addr;
		wb_dat_wr <= data;
		wb_we     <= we;
		wb_cyc    <= 1'b1;
		wb_stb    <= 1'b1;
		while (!done) begin
			@(negedge sys_clk);
			if (wb_ack === 1'b1) begin
				rd   = wb_dat_rd;
				done = 1'b1;
			end else if (allow_reset && sys_rst === 1'b1) begin
				done = 1'b1;
			end else if (n == ACK_TIMEOUT) begin
				$display("No Wishbone ack for the access to address %h", addr);
				main_errors++;
				done = 1'b1;
			end
			n++;
		end
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic wb_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		wb_access(addr, data, 1'b1, 1'b0, unused_rd);
	endtask

	// Queues the read with its expected value for the compare process
	task automatic wb_read_check(input logic [31:0] addr);
		logic [31:0] rd;
		wb_access(addr, 32'h0, 1'b0, 1'b0, rd);
		addr_q.push_back(addr);
		got_q.push_back(rd);
		exp_q.push_back(ref_read(addr));
	endtask

	task automatic set_buttons(input logic [2:0] value);
		@(posedge sys_clk);
		btn   <= value;
		m_btn  = value;
		// Through the two-flop synchronizer
		wait_cycles(4);
	endtask

	//----------------------------------------------------------------------
	// Reset release
	//----------------------------------------------------------------------
	task automatic check_reset_release();
		int   n;
		logic flash_low;
		logic flash_early;
		n           = 0;
		flash_low   = 1'b0;
		flash_early = 1'b0;
		@(negedge sys_clk);
		while (sys_rst !== 1'b0 && n <= HOLD_CYCLES + 4) begin
			if (wb_ack !== 1'b0) begin
				report_mismatch("wb_ack_o", {31'h0, wb_ack}, 32'h0);
			end
			if (irq !== 32'h0) begin
				report_mismatch("irq_o", irq, 32'h0);
			end
			if (led !== 2'b0) begin
				report_mismatch("led_o", {30'h0, led}, 32'h0);
			end
			if (flash_rst_n === 1'b0) begin
				flash_low = 1'b1;
			end else if (flash_rst_n === 1'b1 && flash_low) begin
				flash_early = 1'b1;
			end
			n++;
			@(negedge sys_clk);
		end
		if (sys_rst !== 1'b0) begin
			report_failure("System reset still active after the hold time");
		end
		if (!flash_early) begin
			report_failure("Flash reset was not released before the system reset");
		end
	endtask

	//----------------------------------------------------------------------
	// Compare process and interrupt monitor
	//----------------------------------------------------------------------
	always @(negedge sys_clk) begin
		while (got_q.size() > 0) begin
			cmp_addr = addr_q.pop_front();
			cmp_got  = got_q.pop_front();
			cmp_exp  = exp_q.pop_front();
			if (cmp_got !== cmp_exp) begin
				$display("ERR wb_dat_o addr=%h got=%h exp=%h", cmp_addr, cmp_got, cmp_exp);
				cmp_errors++;
			end
			reads_checked++;
		end
	end

	always @(negedge sys_clk) begin
		cycle++;
		if (wb_ack === 1'b1 && ack_prev) begin
			$display("Wishbone ack stayed high for more than one cycle");
			mon_errors++;
		end
		ack_prev = (wb_ack === 1'b1);
		// Only three interrupt sources exist
		if (irq[31:3] !== 29'h0) begin
			$display("ERR irq_o[31:3] got=%h exp=%h", irq[31:3], 29'h0);
			mon_errors++;
		end
		if (irq[0] === 1'b1) begin
			gpio_pulses++;
		end
		if (irq[1] === 1'b1) begin
			t0_pulses++;
		end
		if (irq[2] === 1'b1) begin
			// Auto-restart period is compare plus one
			if (t1_pulses > 0 && t1_period != 0 && cycle - t1_last != t1_period) begin
				$display("ERR irq_o[2] interval got=%h exp=%h", cycle - t1_last, t1_period);
				mon_errors++;
			end
			t1_last = cycle;
			t1_pulses++;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Errors: bus reads %0d, monitor %0d, sequence %0d",
			cmp_errors, mon_errors, main_errors);
		$display("Checks failed");
		$finish;
	end

	//----------------------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------------------
	initial begin
		void'($urandom(SEED));
		trigger_reset = 1'b1;
		wb_adr        = 32'h0;
		wb_dat_wr     = 32'h0;
		wb_we         = 1'b0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		btn           = 3'b0;
		m_btn         = 3'b0;
		main_errors   = 0;
		cmp_errors    = 0;
		mon_errors    = 0;
		reads_checked = 0;
		cycle         = 0;
		ack_prev      = 1'b0;
		gpio_pulses   = 0;
		t0_pulses     = 0;
		t1_pulses     = 0;
		t1_last       = 0;
		t1_period     = 0;
		clear_model();

		// Power-on reset
		repeat (RESET_CYCLES) @(posedge sys_clk);
		trigger_reset <= 1'b0;
		check_reset_release();

		// Identifiers and unmapped space
		wb_read_check(A_SYS_ID);
		wb_read_check(A_CAPS);
		wb_read_check(32'h0000_3044);
		wb_read_check(32'h0000_0004);
		wb_read_check(32'h0000_100C);

		// LEDs, upper write bits dropped
		for (int i = 0; i < 6; i++) begin
			rnd   = $urandom;
			m_led = rnd[1:0];
			wb_write(A_GPIO_OUT, rnd);
			@(negedge sys_clk);
			if (led !== m_led) begin
				report_mismatch("led_o", {30'h0, led}, {30'h0, m_led});
			end
			wb_read_check(A_GPIO_OUT);
		end

		// Buttons with interrupts masked
		for (int i = 0; i < 4; i++) begin
			rnd = $urandom;
			set_buttons(rnd[2:0]);
			wb_read_check(A_GPIO_IN);
		end

		// Change interrupt enabled, then masked
		wb_write(A_IRQ_EN, 32'h7);
		m_irq_en = 3'h7;
		wb_read_check(A_IRQ_EN);
		base = gpio_pulses;
		set_buttons(~m_btn);
		wait_cycles(8);
		if (gpio_pulses - base != 1) begin
			report_mismatch("irq_o[0] pulses", gpio_pulses - base, 32'h1);
		end
		wb_write(A_IRQ_EN, 32'h0);
		m_irq_en = 3'h0;
		base = gpio_pulses;
		set_buttons(~m_btn);
		wait_cycles(8);
		if (gpio_pulses != base) begin
			report_mismatch("irq_o[0] pulses", gpio_pulses - base, 32'h0);
		end
		wb_read_check(A_GPIO_IN);

		// Timer 0 one-shot
		cmp = $urandom_range(40, 5);
		wb_write(A_T0_CMP, cmp);
		wb_write(A_T0_CNT, 32'h0);
		base = t0_pulses;
		wb_write(A_T0_CTRL, 32'h1);
		waited = 0;
		while (t0_pulses == base && waited < 100) begin
			@(posedge sys_clk);
			waited++;
		end
		if (t0_pulses == base) begin
			report_failure("Timer 0 never raised its interrupt");
		end
		wait_cycles(10);
		if (t0_pulses - base != 1) begin
			report_mismatch("irq_o[1] pulses", t0_pulses - base, 32'h1);
		end
		m_t_cmp[0]  = cmp;
		m_t_cnt[0]  = cmp;
		m_t_ctrl[0] = 32'h0;
		wb_read_check(A_T0_CNT);
		wb_read_check(A_T0_CTRL);
		wb_read_check(A_T0_CMP);

		// Timer 1 auto-restart, interval checked by the monitor
		cmp = $urandom_range(40, 5);
		wb_write(A_T1_CMP, cmp);
		wb_write(A_T1_CNT, 32'h0);
		t1_period = int'(cmp) + 1;
		base = t1_pulses;
		wb_write(A_T1_CTRL, 32'h3);
		waited = 0;
		while (t1_pulses - base < 4 && waited < 400) begin
			@(posedge sys_clk);
			waited++;
		end
		if (t1_pulses - base < 4) begin
			report_failure("Timer 1 did not keep restarting");
		end
		wb_write(A_T1_CTRL, 32'h0);
		m_t_cmp[1]  = cmp;
		m_t_ctrl[1] = 32'h0;
		wb_read_check(A_T1_CTRL);
		wb_read_check(A_T1_CMP);

		// Hard reset clears the written state
		wb_write(A_GPIO_OUT, 32'h3);
		m_led = 2'h3;
		wb_write(A_IRQ_EN, 32'h5);
		m_irq_en = 3'h5;
		wb_write(A_T0_CTRL, 32'h2);
		wb_write(A_T1_CTRL, 32'h2);
		m_t_ctrl[0] = 32'h2;
		m_t_ctrl[1] = 32'h2;
		wb_read_check(A_T0_CTRL);
		wb_access(A_HARD_RST, 32'h1, 1'b1, 1'b1, rdata);
		waited = 0;
		while (sys_rst !== 1'b1 && waited < ACK_TIMEOUT) begin
			@(negedge sys_clk);
			waited++;
		end
		if (sys_rst !== 1'b1) begin
			report_failure("Hard reset write did not raise the system reset");
		end
		@(posedge sys_clk);
		check_reset_release();
		clear_model();
		wb_read_check(A_GPIO_OUT);
		wb_read_check(A_T0_CTRL);
		wb_read_check(A_T1_CTRL);
		wb_read_check(A_IRQ_EN);
		wb_read_check(A_T1_CMP);

		// Let the compare process drain
		wait_cycles(4);
		$display("Errors: bus reads %0d, monitor %0d, sequence %0d (%0d reads compared)",
			cmp_errors, mon_errors, main_errors, reads_checked);
		if (cmp_errors + mon_errors + main_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- wb_csr_bridge.sv
// Wishbone to CSR bridge
// One single-word CSR access per Wishbone cycle, fixed four-cycle latency

module wb_csr_bridge (
	input  logic               sys_clk,
	input  logic               sys_rst_i,

	// Wishbone slave
	input  bus_pkg::wb_addr_t  wb_adr_i,
	input  bus_pkg::wb_data_t  wb_dat_i,
	output bus_pkg::wb_data_t  wb_dat_o,
	input  logic               wb_we_i,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	output logic               wb_ack_o,

	// CSR master
	output bus_pkg::csr_addr_t csr_a_o,
	output logic               csr_we_o,
	output bus_pkg::wb_data_t  csr_dw_o,
	input  bus_pkg::wb_data_t  csr_dr_i
);

	import bus_pkg::*;

	bridge_state_t state;
	logic          req;

	// New bus cycle seen while idle
	assign req = wb_cyc_i && wb_stb_i && (state == BR_IDLE);

	//----------------------------------------------------------------------
	// Control FSM
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst_i) begin
			state    <= BR_IDLE;
			csr_we_o <= 1'b0;
		end else begin
			// Write strobe only in the access cycle
			csr_we_o <= 1'b0;
			case (state)
				BR_IDLE: begin
					if (req) begin
						csr_we_o <= wb_we_i;
						state    <= BR_ACCESS;
					end
				end
				// Slave sees the address now
				BR_ACCESS: state <= BR_LATCH;
				// Slave read data valid here
				BR_LATCH:  state <= BR_ACK;
				BR_ACK:    state <= BR_IDLE;
				default:   state <= BR_IDLE;
			endcase
		end
	end

	//----------------------------------------------------------------------
	// Address and data path
	//----------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (req) begin
			// Word address from byte address
			csr_a_o  <= wb_adr_i[$bits(csr_addr_t)+1:2];
			csr_dw_o <= wb_dat_i;
		end
		if (state == BR_LATCH) begin
			wb_dat_o <= csr_dr_i;
		end
	end

	// Single-cycle ack, reads and writes alike
	assign wb_ack_o = (state == BR_ACK);

endmodule
